// File: Bender.yml
package:
  name: operand_collector

sources:
  - verilog/opc_pkg.sv
  - verilog/gpr_bank.sv
  - verilog/wb_cache.sv
  - verilog/toggle_buffer.sv
  - verilog/operand_fetch.sv
  - verilog/operand_collector.sv
  - target: test
    files:
      - test/operand_collector_tb.sv

// File: project.f
verilog/opc_pkg.sv
verilog/gpr_bank.sv
verilog/wb_cache.sv
verilog/toggle_buffer.sv
verilog/operand_fetch.sv
verilog/operand_collector.sv
test/operand_collector_tb.sv

// File: test/operand_collector_tb.sv
/* self-checking testbench for the operand collector: random writebacks and issues
   against a register model, with a process that compares every output transfer */
module operand_collector_tb;

    localparam int period        = 100;
    localparam int reset_cycles  = 16;
    localparam int n_random      = 40;
    localparam int n_rounds      = 8;
    localparam int drain_cycles  = 40;
    // fill beats, random issues, then per round 2 + 3 + 4 items for the directed phases
    localparam int planned_items = opc_pkg::num_warps * opc_pkg::num_regs + n_random
                                 + n_rounds * 9;
    localparam logic [opc_pkg::num_threads-1:0] full_mask = '1;

    typedef struct packed {
        logic [opc_pkg::wid_bits-1:0]                          wid;
        logic [opc_pkg::num_threads-1:0]                       tmask;
        logic [opc_pkg::meta_bits-1:0]                         meta;
        logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    rs1;
        logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    rs2;
        logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    rs3;
    } expected_t;

    logic                                                  clk = 1'b0;
    logic                                                  reset;
    logic                                                  issue_valid;
    logic                                                  issue_ready;
    logic [opc_pkg::wid_bits-1:0]                          issue_wid;
    logic [opc_pkg::num_threads-1:0]                       issue_tmask;
    logic [opc_pkg::nr_bits-1:0]                           issue_rs1, issue_rs2, issue_rs3;
    logic [opc_pkg::meta_bits-1:0]                         issue_meta;
    logic                                                  wb_valid;
    logic [opc_pkg::wid_bits-1:0]                          wb_wid;
    logic [opc_pkg::nr_bits-1:0]                           wb_rd;
    logic [opc_pkg::num_threads-1:0]                       wb_tmask;
    logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    wb_data;
    logic                                                  wb_sop, wb_eop;
    logic                                                  opd_valid;
    logic                                                  opd_ready;
    logic [opc_pkg::wid_bits-1:0]                          opd_wid;
    logic [opc_pkg::num_threads-1:0]                       opd_tmask;
    logic [opc_pkg::meta_bits-1:0]                         opd_meta;
    logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    opd_rs1_data;
    logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    opd_rs2_data;
    logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    opd_rs3_data;

    // register model, warp by register by lane
    logic [opc_pkg::xlen-1:0] model [opc_pkg::num_warps][opc_pkg::num_regs][opc_pkg::num_threads];
    expected_t exp_q [$];
    int seed         = 32'h678c_243c;
    int stall_seed   = 32'h678c_243c;
    int value_errors = 0;
    int other_errors = 0;

    operand_collector operand_collector_i (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_wid    (issue_wid),
        .issue_tmask  (issue_tmask),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_rs3    (issue_rs3),
        .issue_meta   (issue_meta),
        .wb_valid     (wb_valid),
        .wb_wid       (wb_wid),
        .wb_rd        (wb_rd),
        .wb_tmask     (wb_tmask),
        .wb_data      (wb_data),
        .wb_sop       (wb_sop),
        .wb_eop       (wb_eop),
        .opd_valid    (opd_valid),
        .opd_ready    (opd_ready),
        .opd_wid      (opd_wid),
        .opd_tmask    (opd_tmask),
        .opd_meta     (opd_meta),
        .opd_rs1_data (opd_rs1_data),
        .opd_rs2_data (opd_rs2_data),
        .opd_rs3_data (opd_rs3_data)
    );

    always #(period / 2) clk = ~clk;

    function automatic logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0] expected_operand(
        input int wid, input int rid);
        logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0] v;
        for (int j = 0; j < opc_pkg::num_threads; j++) begin
            v[j] = (rid == 0) ? '0 : model[wid][rid][j];
        end
        return v;
    endfunction

    function automatic logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0] lane_data();
        logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0] v;
        for (int j = 0; j < opc_pkg::num_threads; j++) begin
            v[j] = $random(seed);
        end
        return v;
    endfunction

    function automatic logic [opc_pkg::num_threads-1:0] active_mask();
        int m;
        do begin
            m = $random(seed);
        end while (m[opc_pkg::num_threads-1:0] == '0);
        return m[opc_pkg::num_threads-1:0];
    endfunction

    function automatic logic [opc_pkg::num_threads-1:0] partial_mask();
        logic [opc_pkg::num_threads-1:0] m;
        do begin
            m = active_mask();
        end while (m == full_mask);
        return m;
    endfunction

    function automatic int pick_warp();
        return {$random(seed)} % opc_pkg::num_warps;
    endfunction

    function automatic int any_reg();
        return {$random(seed)} % opc_pkg::num_regs;
    endfunction

    function automatic int nonzero_reg();
        return 1 + {$random(seed)} % (opc_pkg::num_regs - 1);
    endfunction

    task automatic check(input string what,
                         input logic [opc_pkg::num_threads*opc_pkg::xlen-1:0] got,
                         input logic [opc_pkg::num_threads*opc_pkg::xlen-1:0] expected);
        if (got !== expected) begin
            value_errors++;
            $display("[ERROR] %0t %s mismatch: got %0h, expected %0h",
                     $time, what, got, expected);
        end
    endtask

    task automatic compare_output(input expected_t e);
        logic [opc_pkg::num_threads*opc_pkg::xlen-1:0] lanes;
        // lanes outside the thread mask carry no defined value
        for (int j = 0; j < opc_pkg::num_threads; j++) begin
            lanes[j*opc_pkg::xlen +: opc_pkg::xlen] = {opc_pkg::xlen{e.tmask[j]}};
        end
        check("opd_wid", opd_wid, e.wid);
        check("opd_tmask", opd_tmask, e.tmask);
        check("opd_meta", opd_meta, e.meta);
        check("opd_rs1_data", opd_rs1_data & lanes, e.rs1 & lanes);
        check("opd_rs2_data", opd_rs2_data & lanes, e.rs2 & lanes);
        check("opd_rs3_data", opd_rs3_data & lanes, e.rs3 & lanes);
    endtask

    task automatic write_beat(input int wid, input int rd,
                              input logic [opc_pkg::num_threads-1:0] mask,
                              input logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0] data,
                              input logic sop, input logic eop);
        @(negedge clk);
        wb_valid = 1'b1;
        wb_wid   = wid[opc_pkg::wid_bits-1:0];
        wb_rd    = rd[opc_pkg::nr_bits-1:0];
        wb_tmask = mask;
        wb_data  = data;
        wb_sop   = sop;
        wb_eop   = eop;
        for (int j = 0; j < opc_pkg::num_threads; j++) begin
            if (mask[j]) begin
                model[wid][rd][j] = data[j];
            end
        end
    endtask

    // issues one instruction once the previous output has left the collector
    task automatic issue_instr(input int wid, input logic [opc_pkg::num_threads-1:0] tmask,
                               input int rs1, input int rs2, input int rs3);
        expected_t   e;
        logic [63:0] meta;
        meta = {$random(seed), $random(seed)};
        @(negedge clk);
        wb_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        issue_valid = 1'b1;
        issue_wid   = wid[opc_pkg::wid_bits-1:0];
        issue_tmask = tmask;
        issue_rs1   = rs1[opc_pkg::nr_bits-1:0];
        issue_rs2   = rs2[opc_pkg::nr_bits-1:0];
        issue_rs3   = rs3[opc_pkg::nr_bits-1:0];
        issue_meta  = meta[opc_pkg::meta_bits-1:0];
        @(posedge clk);
        while (!issue_ready) begin
            @(posedge clk);
        end
        e.wid   = wid[opc_pkg::wid_bits-1:0];
        e.tmask = tmask;
        e.meta  = meta[opc_pkg::meta_bits-1:0];
        e.rs1   = expected_operand(wid, rs1);
        e.rs2   = expected_operand(wid, rs2);
        e.rs3   = expected_operand(wid, rs3);
        exp_q.push_back(e);
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (reset) begin
            opd_ready = 1'b0;
        end else begin
            opd_ready = ($random(stall_seed) & 3) != 0;
        end
    end

    // every valid cycle is held against the oldest issued instruction, so a stall must not move it
    always @(posedge clk) begin
        if (reset) begin
            if (opd_valid === 1'b1) begin
                other_errors++;
                $display("%0t: opd_valid went high during reset", $time);
            end
        end else if (opd_valid !== 1'b0) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("%0t: output valid while no instruction was outstanding", $time);
            end else begin
                compare_output(exp_q[0]);
                if (opd_ready) begin
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        #((reset_cycles + 40 * planned_items) * period);
        $display("timeout: the run did not finish in the expected number of cycles");
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        int w;
        int r;
        logic [opc_pkg::num_threads-1:0] m;
        logic [opc_pkg::num_threads-1:0] cover_mask;
        logic [opc_pkg::num_threads-1:0] b0, b1, b2;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_wid   = '0;
        issue_tmask = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_rs3   = '0;
        issue_meta  = '0;
        wb_valid    = 1'b0;
        wb_wid      = '0;
        wb_rd       = '0;
        wb_tmask    = '0;
        wb_data     = '0;
        wb_sop      = 1'b0;
        wb_eop      = 1'b0;
        opd_ready   = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int wi = 0; wi < opc_pkg::num_warps; wi++) begin
            for (int ri = 0; ri < opc_pkg::num_regs; ri++) begin
                write_beat(wi, ri, full_mask, lane_data(), 1'b1, 1'b1);
            end
        end
        repeat (n_random) begin
            issue_instr(pick_warp(), active_mask(), any_reg(), any_reg(), any_reg());
        end

        // register 0 stays zero even right after a write to it
        for (int k = 0; k < n_rounds; k++) begin
            w = pick_warp();
            write_beat(w, 0, full_mask, lane_data(), 1'b1, 1'b1);
            issue_instr(w, active_mask(), 0, any_reg(), 0);
        end

        for (int k = 0; k < n_rounds; k++) begin
            w = pick_warp();
            r = nonzero_reg();
            m = partial_mask();
            write_beat(w, r, m, lane_data(), 1'b1, 1'b1);
            issue_instr(w, full_mask, r, any_reg(), r);
            issue_instr(w, m, any_reg(), r, 0);
        end

        // in split writebacks even rounds forward from the cache and odd rounds read the banks
        for (int k = 0; k < n_rounds; k++) begin
            w          = pick_warp();
            r          = nonzero_reg();
            cover_mask = (k % 2 == 0) ? full_mask : partial_mask();
            b0         = '0;
            b1         = '0;
            b2         = '0;
            for (int j = 0; j < opc_pkg::num_threads; j++) begin
                if (cover_mask[j]) begin
                    case ({$random(seed)} % 3)
                        0: b0[j] = 1'b1;
                        1: b1[j] = 1'b1;
                        default: b2[j] = 1'b1;
                    endcase
                end
            end
            write_beat(w, r, b0, lane_data(), 1'b1, 1'b0);
            write_beat(w, r, b1, lane_data(), 1'b0, 1'b0);
            write_beat(w, r, b2, lane_data(), 1'b0, 1'b1);
            issue_instr(w, (k % 2 == 0) ? active_mask() : full_mask, r, nonzero_reg(), r);
        end

        // the last output may still be stalled
        for (int i = 0; i < drain_cycles && exp_q.size() != 0; i++) begin
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            other_errors += exp_q.size();
            $display("%0d issued instructions never appeared at the output", exp_q.size());
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog/gpr_bank.sv
/* general purpose register storage with one memory per lane
   writes are per-lane masked, reads return data one cycle after the address */
module gpr_bank (
    input  logic                                                  clk,
    input  logic                                                  wb_valid,
    input  logic [opc_pkg::wid_bits-1:0]                          wb_wid,
    input  logic [opc_pkg::nr_bits-1:0]                           wb_rd,
    input  logic [opc_pkg::num_threads-1:0]                       wb_tmask,
    input  logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    wb_data,
    input  logic [opc_pkg::wid_bits-1:0]                          rd_wid,
    input  logic [opc_pkg::nr_bits-1:0]                           rd_rid,
    output logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    rd_data
);
    logic [opc_pkg::gpr_addr_bits-1:0] wr_addr;
    logic [opc_pkg::gpr_addr_bits-1:0] rd_addr;

    assign wr_addr = {wb_wid, wb_rd};

    // the read address is captured here, so the fetch FSM presents its next-state value
    always_ff @(posedge clk) begin
        rd_addr <= {rd_wid, rd_rid};
    end

    for (genvar j = 0; j < opc_pkg::num_threads; j++) begin : g_lane
        logic [opc_pkg::xlen-1:0] mem [opc_pkg::num_warps * opc_pkg::num_regs];

        always_ff @(posedge clk) begin
            if (wb_valid && wb_tmask[j]) begin
                mem[wr_addr] <= wb_data[j];
            end
        end

        assign rd_data[j] = mem[rd_addr];
    end

endmodule

// File: verilog/opc_pkg.sv
/* widths and fetch state encodings shared by the operand collector RTL and its testbench
   referenced by scoped name, e.g. opc_pkg::xlen */
package opc_pkg;

    // lanes per warp and the width of one lane's register
    localparam int num_threads = 4;
    localparam int xlen        = 32;

    // architectural registers per warp
    localparam int num_regs = 32;
    localparam int nr_bits  = 5;

    // warps served by this slice
    localparam int num_warps = 4;
    localparam int wid_bits  = 2;

    // opaque instruction metadata carried alongside the operands
    localparam int meta_bits = 48;

    // register file address is the warp id above the register number
    localparam int gpr_addr_bits = wid_bits + nr_bits;

    // fetch FSM encodings
    localparam int state_bits = 2;
    localparam logic [state_bits-1:0] state_idle   = 2'd0;
    localparam logic [state_bits-1:0] state_fetch1 = 2'd1;
    localparam logic [state_bits-1:0] state_fetch2 = 2'd2;
    localparam logic [state_bits-1:0] state_fetch3 = 2'd3;

endpackage

// File: verilog/operand_collector.sv
/* operand collector of one issue slice: takes scored instructions, gathers their
   three source vectors and hands them on with the metadata */
module operand_collector (
    input  logic                                                  clk,
    input  logic                                                  reset,

    input  logic                                                  issue_valid,
    output logic                                                  issue_ready,
    input  logic [opc_pkg::wid_bits-1:0]                          issue_wid,
    input  logic [opc_pkg::num_threads-1:0]                       issue_tmask,
    input  logic [opc_pkg::nr_bits-1:0]                           issue_rs1,
    input  logic [opc_pkg::nr_bits-1:0]                           issue_rs2,
    input  logic [opc_pkg::nr_bits-1:0]                           issue_rs3,
    input  logic [opc_pkg::meta_bits-1:0]                         issue_meta,

    input  logic                                                  wb_valid,
    input  logic [opc_pkg::wid_bits-1:0]                          wb_wid,
    input  logic [opc_pkg::nr_bits-1:0]                           wb_rd,
    input  logic [opc_pkg::num_threads-1:0]                       wb_tmask,
    input  logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    wb_data,
    input  logic                                                  wb_sop,
    input  logic                                                  wb_eop,

    output logic                                                  opd_valid,
    input  logic                                                  opd_ready,
    output logic [opc_pkg::wid_bits-1:0]                          opd_wid,
    output logic [opc_pkg::num_threads-1:0]                       opd_tmask,
    output logic [opc_pkg::meta_bits-1:0]                         opd_meta,
    output logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    opd_rs1_data,
    output logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    opd_rs2_data,
    output logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    opd_rs3_data
);
    logic                                                  data_ready;
    logic                                                  stg_valid_in;
    logic                                                  stg_ready_in;
    logic                                                  opd_fire;
    logic [opc_pkg::wid_bits-1:0]                          lookup_wid;
    logic [opc_pkg::num_threads-1:0]                       lookup_tmask;
    logic [opc_pkg::nr_bits-1:0]                           lookup_rs1, lookup_rs2, lookup_rs3;
    logic                                                  hit_rs1, hit_rs2, hit_rs3;
    logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    hit_data;
    logic [opc_pkg::wid_bits-1:0]                          rd_wid;
    logic [opc_pkg::nr_bits-1:0]                           rd_rid;
    logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    rd_data;

    // an instruction leaves the issue stream only once its operands are in place
    assign stg_valid_in = issue_valid && data_ready;
    assign issue_ready  = stg_ready_in && data_ready;
    assign opd_fire     = opd_valid && opd_ready;

    operand_fetch fetch_i (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_wid    (issue_wid),
        .issue_tmask  (issue_tmask),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_rs3    (issue_rs3),
        .opd_fire     (opd_fire),
        .hit_rs1      (hit_rs1),
        .hit_rs2      (hit_rs2),
        .hit_rs3      (hit_rs3),
        .hit_data     (hit_data),
        .rd_data      (rd_data),
        .lookup_wid   (lookup_wid),
        .lookup_tmask (lookup_tmask),
        .lookup_rs1   (lookup_rs1),
        .lookup_rs2   (lookup_rs2),
        .lookup_rs3   (lookup_rs3),
        .rd_wid       (rd_wid),
        .rd_rid       (rd_rid),
        .data_ready   (data_ready),
        .rs1_data     (opd_rs1_data),
        .rs2_data     (opd_rs2_data),
        .rs3_data     (opd_rs3_data)
    );

    wb_cache cache_i (
        .clk          (clk),
        .reset        (reset),
        .wb_valid     (wb_valid),
        .wb_wid       (wb_wid),
        .wb_rd        (wb_rd),
        .wb_tmask     (wb_tmask),
        .wb_data      (wb_data),
        .wb_sop       (wb_sop),
        .wb_eop       (wb_eop),
        .lookup_wid   (lookup_wid),
        .lookup_rs1   (lookup_rs1),
        .lookup_rs2   (lookup_rs2),
        .lookup_rs3   (lookup_rs3),
        .lookup_tmask (lookup_tmask),
        .hit_rs1      (hit_rs1),
        .hit_rs2      (hit_rs2),
        .hit_rs3      (hit_rs3),
        .hit_data     (hit_data)
    );

    gpr_bank bank_i (
        .clk      (clk),
        .wb_valid (wb_valid),
        .wb_wid   (wb_wid),
        .wb_rd    (wb_rd),
        .wb_tmask (wb_tmask),
        .wb_data  (wb_data),
        .rd_wid   (rd_wid),
        .rd_rid   (rd_rid),
        .rd_data  (rd_data)
    );

    toggle_buffer staging_i (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (stg_valid_in),
        .data_in   ({issue_meta, issue_wid, issue_tmask}),
        .ready_in  (stg_ready_in),
        .valid_out (opd_valid),
        .data_out  ({opd_meta, opd_wid, opd_tmask}),
        .ready_out (opd_ready)
    );

endmodule

// File: verilog/operand_fetch.sv
/* fetch FSM of the operand collector: resolves zero and cached sources at once
   and reads the rest from the register file, one source per cycle */
module operand_fetch (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  issue_valid,
    input  logic [opc_pkg::wid_bits-1:0]                          issue_wid,
    input  logic [opc_pkg::num_threads-1:0]                       issue_tmask,
    input  logic [opc_pkg::nr_bits-1:0]                           issue_rs1,
    input  logic [opc_pkg::nr_bits-1:0]                           issue_rs2,
    input  logic [opc_pkg::nr_bits-1:0]                           issue_rs3,
    input  logic                                                  opd_fire,
    input  logic                                                  hit_rs1,
    input  logic                                                  hit_rs2,
    input  logic                                                  hit_rs3,
    input  logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    hit_data,
    input  logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    rd_data,
    output logic [opc_pkg::wid_bits-1:0]                          lookup_wid,
    output logic [opc_pkg::num_threads-1:0]                       lookup_tmask,
    output logic [opc_pkg::nr_bits-1:0]                           lookup_rs1,
    output logic [opc_pkg::nr_bits-1:0]                           lookup_rs2,
    output logic [opc_pkg::nr_bits-1:0]                           lookup_rs3,
    output logic [opc_pkg::wid_bits-1:0]                          rd_wid,
    output logic [opc_pkg::nr_bits-1:0]                           rd_rid,
    output logic                                                  data_ready,
    output logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    rs1_data,
    output logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    rs2_data,
    output logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    rs3_data
);
    logic [opc_pkg::state_bits-1:0]                        state, state_n;
    logic [opc_pkg::nr_bits-1:0]                           rs2, rs2_n;
    logic [opc_pkg::nr_bits-1:0]                           rs3, rs3_n;
    logic [opc_pkg::nr_bits-1:0]                           rid, rid_n;
    logic [opc_pkg::wid_bits-1:0]                          wid, wid_n;
    logic                                                  rs2_ready, rs2_ready_n;
    logic                                                  rs3_ready, rs3_ready_n;
    logic                                                  data_ready_n;
    logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    rs1_data_n, rs2_data_n, rs3_data_n;

    assign lookup_wid   = issue_wid;
    assign lookup_tmask = issue_tmask;
    assign lookup_rs1   = issue_rs1;
    assign lookup_rs2   = issue_rs2;
    assign lookup_rs3   = issue_rs3;

    // the bank registers the address itself, so it sees the next-state values
    assign rd_wid = wid_n;
    assign rd_rid = rid_n;

    always_comb begin
        state_n      = state;
        rs2_n        = rs2;
        rs3_n        = rs3;
        rid_n        = rid;
        wid_n        = wid;
        rs2_ready_n  = rs2_ready;
        rs3_ready_n  = rs3_ready;
        data_ready_n = data_ready;
        rs1_data_n   = rs1_data;
        rs2_data_n   = rs2_data;
        rs3_data_n   = rs3_data;

        case (state)
            opc_pkg::state_idle: begin
                if (opd_fire) begin
                    data_ready_n = 1'b0;
                end
                // sources are resolved from rs3 down so the lowest pending read goes first
                if (issue_valid && !data_ready_n) begin
                    data_ready_n = 1'b1;
                    if (issue_rs3 == '0 || hit_rs3) begin
                        rs3_data_n  = (issue_rs3 == '0) ? '0 : hit_data;
                        rs3_ready_n = 1'b1;
                    end else begin
                        rs3_ready_n  = 1'b0;
                        rid_n        = issue_rs3;
                        data_ready_n = 1'b0;
                        state_n      = opc_pkg::state_fetch3;
                    end
                    if (issue_rs2 == '0 || hit_rs2) begin
                        rs2_data_n  = (issue_rs2 == '0) ? '0 : hit_data;
                        rs2_ready_n = 1'b1;
                    end else begin
                        rs2_ready_n  = 1'b0;
                        rid_n        = issue_rs2;
                        data_ready_n = 1'b0;
                        state_n      = opc_pkg::state_fetch2;
                    end
                    if (issue_rs1 == '0 || hit_rs1) begin
                        rs1_data_n = (issue_rs1 == '0) ? '0 : hit_data;
                    end else begin
                        rid_n        = issue_rs1;
                        data_ready_n = 1'b0;
                        state_n      = opc_pkg::state_fetch1;
                    end
                end
                wid_n = issue_wid;
                rs2_n = issue_rs2;
                rs3_n = issue_rs3;
            end
            opc_pkg::state_fetch1: begin
                rs1_data_n = rd_data;
                if (!rs2_ready) begin
                    rid_n   = rs2;
                    state_n = opc_pkg::state_fetch2;
                end else if (!rs3_ready) begin
                    rid_n   = rs3;
                    state_n = opc_pkg::state_fetch3;
                end else begin
                    data_ready_n = 1'b1;
                    state_n      = opc_pkg::state_idle;
                end
            end
            opc_pkg::state_fetch2: begin
                rs2_data_n = rd_data;
                if (!rs3_ready) begin
                    rid_n   = rs3;
                    state_n = opc_pkg::state_fetch3;
                end else begin
                    data_ready_n = 1'b1;
                    state_n      = opc_pkg::state_idle;
                end
            end
            default: begin
                rs3_data_n   = rd_data;
                data_ready_n = 1'b1;
                state_n      = opc_pkg::state_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= opc_pkg::state_idle;
            data_ready <= 1'b0;
        end else begin
            state      <= state_n;
            data_ready <= data_ready_n;
        end
        rs2       <= rs2_n;
        rs3       <= rs3_n;
        rid       <= rid_n;
        wid       <= wid_n;
        rs2_ready <= rs2_ready_n;
        rs3_ready <= rs3_ready_n;
        rs1_data  <= rs1_data_n;
        rs2_data  <= rs2_data_n;
        rs3_data  <= rs3_data_n;
    end

endmodule

// File: verilog/toggle_buffer.sv
/* one-entry valid/ready staging register for the instruction metadata
   accepts only when empty, so it passes at most one item every two cycles */
module toggle_buffer (
    input  logic                                                                    clk,
    input  logic                                                                    reset,
    input  logic                                                                    valid_in,
    input  logic [opc_pkg::meta_bits+opc_pkg::wid_bits+opc_pkg::num_threads-1:0]    data_in,
    output logic                                                                    ready_in,
    output logic                                                                    valid_out,
    output logic [opc_pkg::meta_bits+opc_pkg::wid_bits+opc_pkg::num_threads-1:0]    data_out,
    input  logic                                                                    ready_out
);
    logic full;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (valid_in && !full) begin
            full <= 1'b1;
        end else if (full && ready_out) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in && !full) begin
            data_out <= data_in;
        end
    end

    assign ready_in  = !full;
    assign valid_out = full;

endmodule

// File: verilog/wb_cache.sv
/* per-warp cache of the most recently written register, used to forward operands
   without a register file read when the issue mask is fully covered */
module wb_cache (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  wb_valid,
    input  logic [opc_pkg::wid_bits-1:0]                          wb_wid,
    input  logic [opc_pkg::nr_bits-1:0]                           wb_rd,
    input  logic [opc_pkg::num_threads-1:0]                       wb_tmask,
    input  logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    wb_data,
    input  logic                                                  wb_sop,
    input  logic                                                  wb_eop,
    input  logic [opc_pkg::wid_bits-1:0]                          lookup_wid,
    input  logic [opc_pkg::nr_bits-1:0]                           lookup_rs1,
    input  logic [opc_pkg::nr_bits-1:0]                           lookup_rs2,
    input  logic [opc_pkg::nr_bits-1:0]                           lookup_rs3,
    input  logic [opc_pkg::num_threads-1:0]                       lookup_tmask,
    output logic                                                  hit_rs1,
    output logic                                                  hit_rs2,
    output logic                                                  hit_rs3,
    output logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    hit_data
);
    logic [opc_pkg::nr_bits-1:0]                           cache_reg [opc_pkg::num_warps];
    logic [opc_pkg::num_threads-1:0][opc_pkg::xlen-1:0]    cache_data [opc_pkg::num_warps];
    logic [opc_pkg::num_threads-1:0]                       cache_tmask [opc_pkg::num_warps];
    logic [opc_pkg::num_warps-1:0]                         cache_eop;
    logic                                                  wb_update;
    logic                                                  mask_covered;

    // a beat continues the cached packet, or a new packet replaces a finished one
    assign wb_update = wb_valid
                    && ((cache_reg[wb_wid] == wb_rd) || (cache_eop[wb_wid] && wb_sop));

    always_ff @(posedge clk) begin
        if (wb_update) begin
            cache_reg[wb_wid] <= wb_rd;
            for (int j = 0; j < opc_pkg::num_threads; j++) begin
                if (wb_tmask[j]) begin
                    cache_data[wb_wid][j] <= wb_data[j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < opc_pkg::num_warps; w++) begin
                cache_tmask[w] <= '0;
            end
            cache_eop <= '1;
        end else if (wb_update) begin
            cache_tmask[wb_wid] <= wb_sop ? wb_tmask : (cache_tmask[wb_wid] | wb_tmask);
            cache_eop[wb_wid]   <= wb_eop;
        end
    end

    // every lane the instruction needs must already be in the entry
    assign mask_covered = (lookup_tmask & cache_tmask[lookup_wid]) == lookup_tmask;

    assign hit_rs1  = mask_covered && (lookup_rs1 == cache_reg[lookup_wid]);
    assign hit_rs2  = mask_covered && (lookup_rs2 == cache_reg[lookup_wid]);
    assign hit_rs3  = mask_covered && (lookup_rs3 == cache_reg[lookup_wid]);
    assign hit_data = cache_data[lookup_wid];

endmodule
